//--- all.f
matrix_pkg.sv
command_pkg.sv
control_cmd_readpixel.sv
command_decoder.sv
framebuffer.sv
matrix_scan.sv
led_matrix_top.sv
tb_led_matrix.sv

//--- Makefile
# Verilator build and run of the LED matrix testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_led_matrix \
		-Mdir obj_dir -o sim_led_matrix
	./obj_dir/sim_led_matrix | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- tb_led_matrix.sv
`default_nettype none
`timescale 1ns/100ps

module tb_led_matrix
    import matrix_pkg::*;
    import command_pkg::*;
;

    localparam int TABLE_ROWS = 8;
    localparam int FIXED_ROWS = 5;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int PRINT_LIMIT = 10;      // Error lines shown per test.

    typedef struct packed {
        row_addr_t    row;
        column_addr_t column;
        pixel_t       pixel;
        byte_t        brightness;
    } stimulus_t;

    logic clk;
    logic reset;
    byte_t rx_data;
    logic rx_valid;
    logic cmd_error;
    logic pixel_valid;
    row_addr_t pixel_row;
    column_addr_t pixel_column;
    pixel_t pixel_data;
    logic output_enable;

    stimulus_t stimulus [TABLE_ROWS];
    pixel_t expected_fb [FB_DEPTH];     // Expected framebuffer contents.
    fb_addr_t scan_addr;                // Coordinate expected at the scan output.
    byte_t brightness_model;
    logic [31:0] rnd_state;
    int test_errors;
    int pass_count;
    int fail_count;
    event timeout_hit;

    led_matrix_top dut (
        .clk           (clk),
        .reset         (reset),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .cmd_error     (cmd_error),
        .pixel_valid   (pixel_valid),
        .pixel_row     (pixel_row),
        .pixel_column  (pixel_column),
        .pixel_data    (pixel_data),
        .output_enable (output_enable)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // First output after reset is row 0 column 0, then one raster step per cycle.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_addr <= '1;
        end else begin
            scan_addr <= scan_addr + 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lit in the columns below twice the brightness.
    function automatic logic enable_rule(input column_addr_t column, input byte_t level);
        return int'(column) < 2 * int'(level);
    endfunction

    task automatic record_error(input string msg);
        if (test_errors < PRINT_LIMIT) $display("%s", msg);
        test_errors++;
    endtask

    task automatic check_position(input row_addr_t actual_row, input column_addr_t actual_column,
                                  input row_addr_t row, input column_addr_t column);
        if (actual_row !== row || actual_column !== column) begin
            record_error($sformatf("mismatch pixel_row/pixel_column: got %h/%h expected %h/%h",
                                   actual_row, actual_column, row, column));
        end
    endtask

    task automatic check_pixel(input row_addr_t row, input column_addr_t column,
                               input pixel_t actual, input pixel_t expected);
        if (actual !== expected) begin
            record_error($sformatf("mismatch pixel_data at row %0d column %0d: got %h expected %h",
                                   row, column, actual, expected));
        end
    endtask

    task automatic check_enable(input column_addr_t column, input logic actual,
                                input logic expected);
        if (actual !== expected) begin
            record_error($sformatf("mismatch output_enable at column %0d: got %h expected %h",
                                   column, actual, expected));
        end
    endtask

    task automatic check_error(input logic actual, input logic expected);
        if (actual !== expected) begin
            record_error($sformatf("mismatch cmd_error: got %h expected %h", actual, expected));
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("PASS  %s", name);
            pass_count++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    // One strobe cycle, then one idle cycle.
    task automatic send_byte(input byte_t value, input logic expect_error);
        @(posedge clk);
        rx_data <= value;
        rx_valid <= 1'b1;
        @(posedge clk);
        rx_valid <= 1'b0;
        @(negedge clk);
        check_error(cmd_error, expect_error);
    endtask

    task automatic write_pixel(input row_addr_t row, input column_addr_t column,
                               input pixel_t pixel);
        send_byte(CMD_WRITE_PIXEL, 1'b0);
        send_byte({3'b101, row}, 1'b0);          // Upper row bits must be ignored.
        send_byte(column[7:0], 1'b0);
        send_byte(byte_t'(column >> 8), 1'b0);
        send_byte(pixel[15:8], 1'b0);
        send_byte(pixel[7:0], 1'b0);
        @(negedge clk);                          // Write lands a cycle after the toggle.
        expected_fb[{row, column}] = pixel;
    endtask

    task automatic set_brightness(input byte_t level);
        send_byte(CMD_BRIGHTNESS, 1'b0);
        send_byte(level, 1'b0);
        brightness_model = level;
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        while (pixel_valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (pixel_valid !== 1'b1) begin
            $display("timeout: pixel_valid never rose after reset");
            -> timeout_hit;
            forever @(posedge clk);
        end
    endtask

    // Every coordinate passes the output once per frame.
    task automatic scan_frame();
        row_addr_t row;
        column_addr_t column;
        repeat (FB_DEPTH) begin
            @(negedge clk);
            {row, column} = scan_addr;
            if (pixel_valid !== 1'b1) begin
                record_error($sformatf("mismatch pixel_valid at row %0d column %0d: got %h expected 1",
                                       row, column, pixel_valid));
            end
            check_position(pixel_row, pixel_column, row, column);
            check_pixel(row, column, pixel_data, expected_fb[scan_addr]);
            check_enable(column, output_enable, enable_rule(column, brightness_model));
            check_error(cmd_error, 1'b0);
        end
    endtask

    initial begin
        @(timeout_hit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        rx_data = '0;
        rx_valid = 1'b0;
        brightness_model = 8'h80;
        rnd_state = 32'h95af_8911;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        for (int a = 0; a < FB_DEPTH; a++) expected_fb[a] = '0;

        stimulus[0] = '{row: 5'd0,  column: 9'd0,   pixel: 16'hA55A, brightness: 8'h80};
        stimulus[1] = '{row: 5'd3,  column: 9'd300, pixel: 16'h1234, brightness: 8'h00};
        stimulus[2] = '{row: 5'd31, column: 9'd511, pixel: 16'hBEEF, brightness: 8'hFF};
        stimulus[3] = '{row: 5'd17, column: 9'd256, pixel: 16'h0F0F, brightness: 8'h80};
        stimulus[4] = '{row: 5'd5,  column: 9'd255, pixel: 16'hC3D2, brightness: 8'h40};
        for (int t = FIXED_ROWS; t < TABLE_ROWS; t++) begin
            rnd_state = xorshift(rnd_state);
            stimulus[t] = '{row: rnd_state[4:0], column: rnd_state[13:5],
                            pixel: rnd_state[31:16], brightness: rnd_state[21:14]};
        end

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_error(cmd_error, 1'b0);
        if (pixel_valid !== 1'b0) begin
            record_error($sformatf("mismatch pixel_valid during reset: got %h expected 0",
                                   pixel_valid));
        end
        @(posedge clk);
        reset <= 1'b0;

        wait_for_valid();
        scan_frame();
        finish_test("blank frame after reset");

        for (int t = 0; t < TABLE_ROWS; t++) begin
            write_pixel(stimulus[t].row, stimulus[t].column, stimulus[t].pixel);
            set_brightness(stimulus[t].brightness);
            scan_frame();
            finish_test($sformatf("table row %0d at (%0d,%0d) brightness %h", t,
                                  stimulus[t].row, stimulus[t].column, stimulus[t].brightness));
        end

        write_pixel(5'd3, 9'd301, 16'h7E81);
        write_pixel(5'd3, 9'd300, 16'h5678);
        scan_frame();
        finish_test("overwrite keeps neighbors");

        send_byte(8'h5A, 1'b1);
        @(negedge clk);
        check_error(cmd_error, 1'b0);           // Pulse lasts one cycle.
        scan_frame();
        finish_test("unknown opcode");

        for (int n = 0; n < 10; n++) begin
            rnd_state = xorshift(rnd_state);
            write_pixel(rnd_state[4:0], rnd_state[13:5], rnd_state[31:16]);
            scan_frame();
            finish_test($sformatf("random write %0d", n));
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- led_matrix_top.sv
`default_nettype none
`timescale 1ns/100ps

module led_matrix_top
    import matrix_pkg::*;
    import command_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  byte_t        rx_data,
    input  logic         rx_valid,
    output logic         cmd_error,
    output logic         pixel_valid,
    output row_addr_t    pixel_row,
    output column_addr_t pixel_column,
    output pixel_t       pixel_data,
    output logic         output_enable
);

    fb_write_t fb_write;
    logic ram_write_enable;
    logic ram_access_start;
    byte_t brightness;
    row_addr_t read_row;
    column_addr_t read_column;
    pixel_t read_data;

    command_decoder u_decoder (
        .clk              (clk),
        .reset            (reset),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .brightness       (brightness),
        .cmd_error        (cmd_error),
        .fb_write         (fb_write),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start)
    );

    framebuffer u_framebuffer (
        .clk              (clk),
        .reset            (reset),
        .fb_write         (fb_write),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start),
        .read_row         (read_row),
        .read_column      (read_column),
        .read_data        (read_data)
    );

    matrix_scan u_scan (
        .clk           (clk),
        .reset         (reset),
        .brightness    (brightness),
        .read_data     (read_data),
        .read_row      (read_row),
        .read_column   (read_column),
        .pixel_valid   (pixel_valid),
        .output_enable (output_enable),
        .pixel_row     (pixel_row),
        .pixel_column  (pixel_column),
        .pixel_data    (pixel_data)
    );

endmodule

`default_nettype wire

//--- matrix_scan.sv
`default_nettype none
`timescale 1ns/100ps

module matrix_scan
    import matrix_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  byte_t        brightness,
    input  pixel_t       read_data,
    output row_addr_t    read_row,
    output column_addr_t read_column,
    output logic         pixel_valid,
    output logic         output_enable,
    output row_addr_t    pixel_row,
    output column_addr_t pixel_column,
    output pixel_t       pixel_data
);

    logic last_column;
    byte_t column_level;    // Column position on the brightness scale.

    assign last_column = (read_column == column_addr_t'(COLUMNS - 1));

    // Raster address counters, column fastest.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_row <= '0;
            read_column <= '0;
        end else begin
            read_column <= read_column + 1'b1;
            if (last_column) begin
                read_column <= '0;
                read_row <= read_row + 1'b1;  // Wraps to row 0 after the last row.
            end
        end
    end

    // Coordinates follow the read address by the memory latency.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pixel_valid <= 1'b0;
            pixel_row <= '0;
            pixel_column <= '0;
        end else begin
            pixel_valid <= 1'b1;
            pixel_row <= read_row;
            pixel_column <= read_column;
        end
    end

    assign pixel_data = read_data;    // Already registered in the framebuffer.

    // Left part of each row lit, width set by brightness.
    assign column_level = pixel_column[COLUMN_BITS-1 -: 8];
    assign output_enable = (column_level < brightness);

endmodule

`default_nettype wire

//--- framebuffer.sv
`default_nettype none
`timescale 1ns/100ps

module framebuffer
    import matrix_pkg::*;
    import command_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fb_write_t    fb_write,
    input  logic         ram_write_enable,
    input  logic         ram_access_start,
    input  row_addr_t    read_row,
    input  column_addr_t read_column,
    output pixel_t       read_data
);

    logic access_prev;      // Toggle value seen last cycle.
    logic write_strobe;
    fb_addr_t write_addr;
    fb_addr_t read_addr;

    assign write_strobe = ram_write_enable && (ram_access_start != access_prev);
    assign write_addr = {fb_write.row, fb_write.column};
    assign read_addr = {read_row, read_column};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            access_prev <= 1'b0;
        end else begin
            access_prev <= ram_access_start;
        end
    end

    for (genvar lane = 0; lane < BYTES_PER_PIXEL; lane++) begin : g_lane
        byte_t lane_mem [FB_DEPTH];
        logic [FB_DEPTH-1:0] lane_written;   // Unwritten bytes read as zero.
        logic lane_write;
        byte_t lane_data;

        assign lane_write = write_strobe && (fb_write.pixel == pixel_select_t'(lane));
        assign read_data[lane*8 +: 8] = lane_data;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                lane_written <= '0;
            end else if (lane_write) begin
                lane_written[write_addr] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (lane_write) begin
                lane_mem[write_addr] <= fb_write.data;
            end
            lane_data <= lane_written[read_addr] ? lane_mem[read_addr] : '0;
        end
    end

endmodule

`default_nettype wire

//--- command_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module command_decoder
    import matrix_pkg::*;
    import command_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  byte_t     rx_data,
    input  logic      rx_valid,
    output byte_t     brightness,
    output logic      cmd_error,
    output fb_write_t fb_write,
    output logic      ram_write_enable,
    output logic      ram_access_start
);

    decoder_state_t state;

    logic handler_enable;
    logic handler_done;

    // Payload bytes of a pixel command go straight to the handler.
    assign handler_enable = rx_valid && (state == DEC_PIXEL);

    control_cmd_readpixel u_readpixel (
        .clk              (clk),
        .reset            (reset),
        .enable           (handler_enable),
        .data_in          (rx_data),
        .fb_write         (fb_write),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start),
        .done             (handler_done)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= DEC_IDLE;
            brightness <= BRIGHTNESS_RESET;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;    // Single-cycle pulse.
            case (state)
                DEC_IDLE: begin
                    if (rx_valid) begin
                        case (rx_data)
                            CMD_WRITE_PIXEL: state <= DEC_PIXEL;
                            CMD_BRIGHTNESS:  state <= DEC_BRIGHTNESS;
                            default:         cmd_error <= 1'b1;
                        endcase
                    end
                end
                DEC_PIXEL: begin
                    if (handler_done) begin
                        state <= DEC_IDLE;
                    end
                end
                DEC_BRIGHTNESS: begin
                    if (rx_valid) begin
                        brightness <= rx_data;
                        state <= DEC_IDLE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- control_cmd_readpixel.sv
`default_nettype none
`timescale 1ns/100ps

module control_cmd_readpixel
    import matrix_pkg::*;
    import command_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      enable,
    input  byte_t     data_in,
    output fb_write_t fb_write,
    output logic      ram_write_enable,
    output logic      ram_access_start,
    output logic      done
);

    typedef enum logic [1:0] {
        HS_ROW,
        HS_COLUMN,
        HS_PIXEL,
        HS_DONE
    } handler_state_t;

    handler_state_t state;

    row_addr_t row;
    logic [COLUMN_BYTES*8-1:0] column_bits;   // Little-endian column assembly.
    column_count_t column_byte;
    pixel_select_t pixel_select;              // Select for the next pixel byte.
    pixel_select_t pixel_out;                 // Select of the byte on fb_write.
    byte_t data_out;

    assign fb_write = '{
        row:    row,
        column: column_bits[COLUMN_BITS-1:0],
        pixel:  pixel_out,
        data:   data_out
    };

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= HS_ROW;
            row <= '0;
            column_bits <= '0;
            column_byte <= '0;
            pixel_select <= '0;
            pixel_out <= '0;
            data_out <= '0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                HS_ROW: begin
                    if (enable) begin
                        row <= data_in[ROW_BITS-1:0];    // Upper bits are ignored.
                        column_byte <= '0;
                        ram_write_enable <= 1'b0;
                        done <= 1'b0;
                        state <= HS_COLUMN;
                    end
                end
                HS_COLUMN: begin
                    if (enable) begin
                        column_bits[column_byte*8 +: 8] <= data_in; // LSB first.
                        if (column_byte == column_count_t'(COLUMN_BYTES - 1)) begin
                            pixel_select <= pixel_select_t'(BYTES_PER_PIXEL - 1);
                            ram_write_enable <= 1'b1;
                            state <= HS_PIXEL;
                        end else begin
                            column_byte <= column_byte + 1'b1;
                        end
                    end
                end
                HS_PIXEL: begin
                    if (enable) begin
                        data_out <= data_in;
                        pixel_out <= pixel_select;
                        ram_access_start <= ~ram_access_start; // One toggle per byte.
                        if (pixel_select == '0) begin
                            done <= 1'b1;
                            state <= HS_DONE;
                        end else begin
                            pixel_select <= pixel_select - 1'b1;
                        end
                    end
                end
                HS_DONE: begin
                    // Write enable drops with the toggle, so clearing it writes nothing.
                    done <= 1'b0;
                    ram_write_enable <= 1'b0;
                    ram_access_start <= 1'b0;
                    row <= '0;
                    column_bits <= '0;
                    data_out <= '0;
                    state <= HS_ROW;
                end
                default: begin
                    state <= HS_ROW;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- command_pkg.sv
`default_nettype none

package command_pkg;
    import matrix_pkg::*;

    typedef enum logic [7:0] {
        CMD_WRITE_PIXEL = 8'h72,  // "r"
        CMD_BRIGHTNESS  = 8'h62   // "b"
    } cmd_opcode_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_PIXEL,
        DEC_BRIGHTNESS
    } decoder_state_t;

    localparam byte_t BRIGHTNESS_RESET = 8'h80;

    // Byte that the pixel handler currently presents to the framebuffer.
    typedef struct packed {
        row_addr_t     row;
        column_addr_t  column;
        pixel_select_t pixel;
        byte_t         data;
    } fb_write_t;

endpackage

`default_nettype wire

//--- matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    localparam int ROW_BITS = 5;             // Row address width.
    localparam int COLUMN_BITS = 9;          // Column address width.
    localparam int COLUMN_BYTES = 2;         // Host bytes per column address.
    localparam int BYTES_PER_PIXEL = 2;      // Host bytes per pixel word.
    localparam int PIXEL_SELECT_BITS = 1;    // Byte index width within a pixel.

    // Width of the column byte counter, never zero.
    localparam int COLUMN_COUNT_BITS = (COLUMN_BYTES > 1) ? $clog2(COLUMN_BYTES) : 1;

    localparam int ROWS = 1 << ROW_BITS;
    localparam int COLUMNS = 1 << COLUMN_BITS;
    localparam int FB_ADDR_BITS = ROW_BITS + COLUMN_BITS;
    localparam int FB_DEPTH = ROWS * COLUMNS; // Also the frame length in cycles.

    typedef logic [7:0] byte_t;
    typedef logic [ROW_BITS-1:0] row_addr_t;
    typedef logic [COLUMN_BITS-1:0] column_addr_t;
    typedef logic [PIXEL_SELECT_BITS-1:0] pixel_select_t; // 1 selects the high byte.
    typedef logic [BYTES_PER_PIXEL*8-1:0] pixel_t;
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;            // {row, column}.
    typedef logic [COLUMN_COUNT_BITS-1:0] column_count_t;

endpackage

`default_nettype wire
